//--- list.f
rtl/alu_config_pkg.sv
rtl/alu_feedback_pkg.sv
rtl/delay_line.sv
rtl/thread_counter.sv
rtl/s_register_file.sv
rtl/alu_feedback_path.sv
tb/tb_alu_feedback_path.sv

//--- rtl/alu_config_pkg.sv
// ALU feedback path configuration
// Sizing, S address and pipeline depth constants with the basic word types

`default_nettype none

package alu_config_pkg;

    // --------------------
    // Data and address widths

    localparam int WORD_WIDTH = 16;
    localparam int ADDR_WIDTH = 10;

    // Write address that selects the S register
    localparam logic [ADDR_WIDTH-1:0] S_WRITE_ADDR = 10'h3F8;

    // --------------------
    // Multithreading

    // Barrel pipeline needs at least two threads
    localparam int THREAD_COUNT = 4;
    localparam int THREAD_WIDTH = $clog2(THREAD_COUNT);

    // --------------------
    // Pipeline depths

    localparam int IN_SYNC_DEPTH  = 2;
    localparam int OUT_SYNC_DEPTH = 1;

    // Input sync, one flag/R register stage, then output sync
    localparam int FEEDBACK_LATENCY = IN_SYNC_DEPTH + 1 + OUT_SYNC_DEPTH;

    typedef logic [WORD_WIDTH-1:0]   word_t;
    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [THREAD_WIDTH-1:0] thread_t;

endpackage

`default_nettype wire

//--- rtl/alu_feedback_path.sv
// ALU feedback path
// Returns R, its zero and negative flags, and the per-thread stored result S
// to the forward path, four cycles after the ALU results arrive

`timescale 1ns/1ps
`default_nettype none

module alu_feedback_path
    import alu_config_pkg::*;
    import alu_feedback_pkg::*;
(
    input  wire         clock,
    input  wire         arst_n,
    input  alu_result_t result,
    output feedback_t   feedback
);

    // --------------------
    // Stages 3 and 2

    // Bring the ALU results up to stage 1
    alu_result_t stage1;

    delay_line #(
        .DEPTH     (IN_SYNC_DEPTH),
        .payload_t (alu_result_t)
    ) input_sync (
        .clock  (clock),
        .arst_n (arst_n),
        .in     (result),
        .out    (stage1)
    );

    // --------------------
    // Stage 1, S write

    // Commit only real instructions: not stalled, not cancelled
    logic s_write_enable;

    // Single S address, plain equality compare
    assign s_write_enable = stage1.io_ready && !stage1.cancel
                            && (stage1.db == S_WRITE_ADDR);

    thread_t s_write_thread;
    thread_t s_read_thread;

    thread_counter thread_counter (
        .clock   (clock),
        .arst_n  (arst_n),
        .current (s_write_thread),
        .next    (s_read_thread)
    );

    // Read address one thread ahead
    // so the word is out when that thread reaches stage 0
    word_t s_stage0;

    s_register_file s_register_file (
        .clock        (clock),
        .write_enable (s_write_enable),
        .write_thread (s_write_thread),
        .write_data   (stage1.rb),
        .read_thread  (s_read_thread),
        .read_data    (s_stage0)
    );

    // --------------------
    // Stage 1, R flags

    logic r_zero_raw;
    logic r_negative_raw;

    assign r_zero_raw     = (stage1.ra == '0);
    // Two's complement sign bit
    assign r_negative_raw = stage1.ra[WORD_WIDTH-1];

    // R and flags into stage 0, lined up with the S read
    word_t ra_stage0;
    logic  r_zero_stage0;
    logic  r_negative_stage0;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ra_stage0         <= '0;
            r_zero_stage0     <= 1'b0;
            r_negative_stage0 <= 1'b0;
        end else begin
            ra_stage0         <= stage1.ra;
            r_zero_stage0     <= r_zero_raw;
            r_negative_stage0 <= r_negative_raw;
        end
    end

    // --------------------
    // Stage 0

    feedback_t feedback_stage0;

    always_comb begin
        feedback_stage0.r          = ra_stage0;
        feedback_stage0.r_zero     = r_zero_stage0;
        feedback_stage0.r_negative = r_negative_stage0;
        feedback_stage0.s          = s_stage0;
    end

    // Output register toward the forward path
    delay_line #(
        .DEPTH     (OUT_SYNC_DEPTH),
        .payload_t (feedback_t)
    ) output_sync (
        .clock  (clock),
        .arst_n (arst_n),
        .in     (feedback_stage0),
        .out    (feedback)
    );

    // --------------------
    // Checks

    // A cancelled instruction never reaches the S write once through the input sync
    assert property (@(posedge clock) disable iff (!arst_n)
        arst_n && result.cancel |-> ##IN_SYNC_DEPTH !s_write_enable)
        else $error("S written by a cancelled instruction");

endmodule

`default_nettype wire

//--- rtl/alu_feedback_pkg.sv
// ALU feedback path payloads
// Packed structs for the ALU results coming in and the feedback going out

`default_nettype none

package alu_feedback_pkg;

    import alu_config_pkg::*;

    // --------------------
    // Instruction results from the ALU

    // 44 bits, MSB first as listed
    typedef struct packed {
        // Instruction was not stalled on I/O
        logic  io_ready;
        // Instruction was annulled, must not commit
        logic  cancel;
        // Write address of the second result
        addr_t db;
        // First result, returned as R
        word_t ra;
        // Second result, candidate for S
        word_t rb;
    } alu_result_t;

    // --------------------
    // Feedback to the forward path

    // 34 bits
    typedef struct packed {
        // Previous result
        word_t r;
        // R is all zero
        logic  r_zero;
        // Top bit of R is set
        logic  r_negative;
        // Stored result of the thread
        word_t s;
    } feedback_t;

endpackage

`default_nettype wire

//--- rtl/delay_line.sv
// Delay line
// Chain of DEPTH registers over any payload type, cleared on reset

`timescale 1ns/1ps
`default_nettype none

module delay_line
    import alu_config_pkg::*;
#(
    parameter int  DEPTH     = 1,
    // Plain word unless the instance says otherwise
    parameter type payload_t = word_t
) (
    input  wire      clock,
    input  wire      arst_n,
    input  payload_t in,
    output payload_t out
);

    // --------------------
    // Register chain

    // Index 0 takes the input, last index drives the output
    payload_t stages [DEPTH];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= in;
            // Shift one step toward the output
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    // Latency equals DEPTH
    assign out = stages[DEPTH-1];

endmodule

`default_nettype wire

//--- rtl/s_register_file.sv
// S register file
// Simple dual-port memory with one S word per thread and a registered read

`timescale 1ns/1ps
`default_nettype none

module s_register_file
    import alu_config_pkg::*;
(
    input  wire     clock,

    // Write port, from stage 1
    input  wire     write_enable,
    input  thread_t write_thread,
    input  word_t   write_data,

    // Read port, always enabled
    input  thread_t read_thread,
    output word_t   read_data
);

    // --------------------
    // Storage

    // Contents undefined until each thread writes
    word_t mem [THREAD_COUNT];

    // Write side
    always_ff @(posedge clock) begin
        if (write_enable) begin
            mem[write_thread] <= write_data;
        end
    end

    // --------------------
    // Registered read

    // Same-cycle write to the same word returns the old word
    always_ff @(posedge clock) begin
        read_data <= mem[read_thread];
    end

    // --------------------
    // Checks

    // Read leads write by one thread, so the two ports never collide
    assert property (@(posedge clock)
        write_enable |-> write_thread != read_thread)
        else $error("S write targets the thread being read");

endmodule

`default_nettype wire

//--- rtl/thread_counter.sv
// Thread counter
// Round-robin current and next thread numbers for the barrel pipeline

`timescale 1ns/1ps
`default_nettype none

module thread_counter
    import alu_config_pkg::*;
(
    input  wire     clock,
    input  wire     arst_n,
    output thread_t current,
    output thread_t next
);

    // Starts behind by the input sync depth
    // so current matches the thread in stage 1
    localparam thread_t RESET_THREAD =
        thread_t'((THREAD_COUNT - (IN_SYNC_DEPTH % THREAD_COUNT)) % THREAD_COUNT);

    localparam thread_t LAST_THREAD = thread_t'(THREAD_COUNT - 1);

    // --------------------
    // Next thread, wraps at THREAD_COUNT

    always_comb begin
        if (current == LAST_THREAD) begin
            next = '0;
        end else begin
            next = current + 1'b1;
        end
    end

    // One thread per cycle, never holds
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            current <= RESET_THREAD;
        end else begin
            current <= next;
        end
    end

    // --------------------
    // Checks

    // Next is current plus one, modulo the thread count
    assert property (@(posedge clock) disable iff (!arst_n)
        int'(next) == (int'(current) + 1) % THREAD_COUNT)
        else $error("thread_counter next is not current plus one modulo the thread count");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ALU feedback path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_alu_feedback_path \
    -Mdir obj_dir \
    -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/Vtb_alu_feedback_path)"
run_status=$?
echo "$output"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi

//--- tb/feedback_stimulus.txt
# io_ready cancel db ra rb | expected: r zero negative check_s s (all hex)
# Line k belongs to thread k mod 4, s is the stored S of thread (k+1) mod 4
1 0 3f8 1234 a000 1234 0 0 0 0000
1 0 3f8 0000 b111 0000 1 0 0 0000
1 0 3f8 8000 c222 8000 0 1 0 0000
1 0 3f8 7fff d333 7fff 0 0 0 0000
1 0 3f7 ffff 1111 ffff 0 1 1 b111
1 1 3f8 0001 2222 0001 0 0 1 c222
0 0 3f8 4000 3333 4000 0 0 1 d333
1 0 3f8 0000 4444 0000 1 0 1 a000
1 0 3f8 8001 5555 8001 0 1 1 b111
1 0 3f8 00ff 6666 00ff 0 0 1 c222
1 0 3f8 ff00 7777 ff00 0 1 1 4444
1 0 000 0000 8888 0000 1 0 1 5555
0 1 3f8 5a5a 9999 5a5a 0 0 1 6666
1 0 3f9 a5a5 aaaa a5a5 0 1 1 7777
1 0 1f8 0080 bbbb 0080 0 0 1 4444
1 0 3f8 8000 0000 8000 0 1 1 5555
1 0 3f8 0000 ffff 0000 1 0 1 6666
1 1 3f8 7ffe 1234 7ffe 0 0 1 7777
1 0 3f8 c000 abcd c000 0 1 1 0000
1 0 0f8 0001 eeee 0001 0 0 1 ffff
0 0 3f8 ffff 0101 ffff 0 1 1 6666
1 0 3f8 1000 2468 1000 0 0 1 abcd
1 1 3f8 0000 1357 0000 1 0 1 0000
1 0 3f8 8fff fedc 8fff 0 1 1 ffff
1 0 3f8 0002 0f0f 0002 0 0 1 2468
1 0 2f8 0000 9876 0000 1 0 1 abcd
1 0 3f8 e000 3c3c e000 0 1 1 fedc
0 1 3f8 0400 1111 0400 0 0 1 0f0f
1 0 3f8 ffff 5a5a ffff 0 1 1 2468
1 0 3f8 0000 c3c3 0000 1 0 1 3c3c
1 0 3f0 8000 7e7e 8000 0 1 1 fedc
1 0 3f8 0010 0001 0010 0 0 1 5a5a
0 0 000 0000 0000 0000 1 0 1 c3c3
0 0 000 0000 0000 0000 1 0 1 3c3c
0 0 000 0000 0000 0000 1 0 1 0001
0 0 000 0000 0000 0000 1 0 1 5a5a

//--- tb/tb_alu_feedback_path.sv
// Testbench for the ALU feedback path
// Replays the stimulus file and checks R, its flags and S four cycles later

`timescale 1ns/1ps
`default_nettype none

module tb_alu_feedback_path
    import alu_config_pkg::*;
    import alu_feedback_pkg::*;
();

    localparam int CLOCK_HALF   = 4;
    localparam int RESET_CYCLES = 2;
    localparam int MAX_LINES    = 64;

    // Expected feedback of one instruction
    typedef struct packed {
        word_t r;
        logic  r_zero;
        logic  r_negative;
        // S compare only once the thread was written
        logic  check_s;
        word_t s;
    } expected_t;

    logic        clock;
    logic        arst_n;
    alu_result_t result;
    feedback_t   feedback;

    alu_result_t stim_result [MAX_LINES];
    expected_t   stim_expected [MAX_LINES];
    expected_t   expected_queue [$];

    int line_count    = 0;
    int checked_count = 0;
    int error_count   = 0;
    int cycle_count   = 0;
    int cycle_limit   = 20;

    alu_feedback_path i_alu_feedback_path (
        .clock    (clock),
        .arst_n   (arst_n),
        .result   (result),
        .feedback (feedback)
    );

    initial begin
        clock = 1'b0;
        forever #CLOCK_HALF clock = ~clock;
    end

    // --------------------
    // Reporting

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            abort_run("feedback value mismatch");
        end
    endtask

    // --------------------
    // Stimulus file

    task automatic load_stimulus();
        int    fd;
        int    fields;
        string line;
        logic  io_ready;
        logic  cancel;
        addr_t db;
        word_t ra;
        word_t rb;
        word_t exp_r;
        logic  exp_zero;
        logic  exp_negative;
        logic  check_s;
        word_t exp_s;
        fd = $fopen("tb/feedback_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus file tb/feedback_stimulus.txt");
        end
        while ($fgets(line, fd) != 0) begin
            // Skip comments and blank lines
            if (line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", io_ready, cancel, db,
                                 ra, rb, exp_r, exp_zero, exp_negative, check_s, exp_s);
                if (fields != 10) begin
                    abort_run("stimulus line does not hold ten hex fields");
                end
                if (line_count >= MAX_LINES) begin
                    abort_run("stimulus file holds too many lines");
                end
                stim_result[line_count].io_ready       = io_ready;
                stim_result[line_count].cancel         = cancel;
                stim_result[line_count].db             = db;
                stim_result[line_count].ra             = ra;
                stim_result[line_count].rb             = rb;
                stim_expected[line_count].r            = exp_r;
                stim_expected[line_count].r_zero       = exp_zero;
                stim_expected[line_count].r_negative   = exp_negative;
                stim_expected[line_count].check_s      = check_s;
                stim_expected[line_count].s            = exp_s;
                line_count++;
            end
        end
        $fclose(fd);
        if (line_count == 0) begin
            abort_run("stimulus file holds no instructions");
        end
        // Reset, every line, pipeline drain and some margin
        cycle_limit = line_count + 20;
    endtask

    // --------------------
    // Output checks

    task automatic check_feedback(input expected_t expected);
        check_value("feedback.r", feedback.r, expected.r);
        check_value("feedback.r_zero", word_t'(feedback.r_zero), word_t'(expected.r_zero));
        check_value("feedback.r_negative", word_t'(feedback.r_negative),
                    word_t'(expected.r_negative));
        if (expected.check_s) begin
            check_value("feedback.s", feedback.s, expected.s);
        end
        checked_count++;
    endtask

    // Before the first instruction emerges, S is left out since the memory has no reset
    task automatic check_bubble(input int cycle);
        logic zero_expected;
        // Flag register leaves reset low, then sees the cleared input stages with ra zero
        zero_expected = (cycle >= FEEDBACK_LATENCY - IN_SYNC_DEPTH);
        check_value("feedback.r", feedback.r, '0);
        check_value("feedback.r_zero", word_t'(feedback.r_zero), word_t'(zero_expected));
        check_value("feedback.r_negative", word_t'(feedback.r_negative), '0);
    endtask

    // --------------------
    // Main sequence

    initial begin
        arst_n = 1'b0;
        result = '0;
        load_stimulus();
        repeat (RESET_CYCLES - 1) @(posedge clock);
        @(negedge clock);
        check_bubble(0);
        // Release edge drives line 0, so line k belongs to thread k mod THREAD_COUNT
        for (int k = 0; k < line_count + FEEDBACK_LATENCY; k++) begin
            @(posedge clock);
            arst_n <= 1'b1;
            if (k < line_count) begin
                result <= stim_result[k];
                expected_queue.push_back(stim_expected[k]);
            end else begin
                result <= '0;
            end
            @(negedge clock);
            if (k >= FEEDBACK_LATENCY) begin
                check_feedback(expected_queue.pop_front());
            end else begin
                check_bubble(k);
            end
        end
        if (error_count == 0 && checked_count == line_count) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            abort_run("not every stimulus line reached a feedback check");
        end
    end

    // Watchdog
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            abort_run("timeout, the run took more cycles than the stimulus needs");
        end
    end

endmodule

`default_nettype wire
